// ==== riscv_pkg.sv ====
// RISC-V execute pipe types
package riscv_pkg;

    // Register file size
    localparam int NUM_REGS = 32;

    // Register index, x0 to x31
    typedef logic [4:0] reg_addr_t;

    // A operand source
    typedef enum logic [0:0] {
        src_rs1 = 1'b0,
        src_pc  = 1'b1
    } src_a_e;

    // B operand source
    typedef enum logic [0:0] {
        src_rs2 = 1'b0,
        src_imm = 1'b1
    } src_b_e;

    // Forward select per register operand
    // Code 2'b11 never driven
    typedef enum logic [1:0] {
        fwd_none = 2'b00,
        fwd_mem  = 2'b01,
        fwd_wb   = 2'b10
    } fwd_sel_e;

    // ALU operations
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_sll  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_slt  = 4'd8,
        alu_sltu = 4'd9
    } alu_op_e;

endpackage

// ==== fu.sv ====
// Operand forwarding unit
`timescale 1ns/100ps

module fu (
    input  riscv_pkg::reg_addr_t ex_rs1,
    input  riscv_pkg::reg_addr_t ex_rs2,
    input  riscv_pkg::src_a_e    src_a,
    input  riscv_pkg::src_b_e    src_b,
    input  logic                 mem_valid,
    input  logic                 mem_reg_write,
    input  riscv_pkg::reg_addr_t mem_rd,
    input  logic                 wb_valid,
    input  logic                 wb_reg_write,
    input  riscv_pkg::reg_addr_t wb_rd,
    output riscv_pkg::fwd_sel_e  fwd_a,
    output riscv_pkg::fwd_sel_e  fwd_b
);

    // Stage may forward only if it carries a real register write
    logic mem_fwd_ok;
    logic wb_fwd_ok;

    assign mem_fwd_ok = mem_valid && mem_reg_write && (mem_rd != '0);
    assign wb_fwd_ok  = wb_valid && wb_reg_write && (wb_rd != '0);

    // Source for one register operand, MEM first since it is younger
    function automatic riscv_pkg::fwd_sel_e pick_src(input riscv_pkg::reg_addr_t rs);
        riscv_pkg::fwd_sel_e sel;
        sel = riscv_pkg::fwd_none;
        if (mem_fwd_ok && (rs == mem_rd)) begin
            sel = riscv_pkg::fwd_mem;
        end else if (wb_fwd_ok && (rs == wb_rd)) begin
            sel = riscv_pkg::fwd_wb;
        end
        return sel;
    endfunction

    always_comb begin
        // pc and imm operands never need a forward
        fwd_a = riscv_pkg::fwd_none;
        fwd_b = riscv_pkg::fwd_none;
        if (src_a == riscv_pkg::src_rs1) begin
            fwd_a = pick_src(ex_rs1);
        end
        if (src_b == riscv_pkg::src_rs2) begin
            fwd_b = pick_src(ex_rs2);
        end
    end

    // x0 must never be fed from the pipe
    always_comb begin
        a_no_x0_fwd: assert final (!(fwd_a == riscv_pkg::fwd_mem && mem_rd == '0))
            else $error("fu: fwd_a selects MEM while mem_rd is x0");
        a_legal_sel: assert final (fwd_a != 2'b11 && fwd_b != 2'b11)
            else $error("fu: illegal forward select");
    end

endmodule

// ==== regfile.sv ====
// Integer register file
`timescale 1ns/100ps

module regfile #(
    parameter int XLEN = 32
) (
    input  logic                 clk,
    input  logic                 rst,
    input  riscv_pkg::reg_addr_t rs1,
    input  riscv_pkg::reg_addr_t rs2,
    input  logic                 we,
    input  riscv_pkg::reg_addr_t rd,
    input  logic [XLEN-1:0]      wdata,
    output logic [XLEN-1:0]      rs1_data,
    output logic [XLEN-1:0]      rs2_data
);

    logic [XLEN-1:0] regs [riscv_pkg::NUM_REGS];

    // Single write port, x0 stays zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < riscv_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != '0)) begin
            regs[rd] <= wdata;
        end
    end

    // Reads see the old value during a same-cycle write
    // WB forward covers that case
    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

    // x0 holds zero across any write traffic
    a_x0_zero: assert property (
        @(posedge clk) disable iff (rst)
        (rs1 != '0 || rs1_data == '0) && (rs2 != '0 || rs2_data == '0)
    ) else $error("regfile: read of x0 returned nonzero");

endmodule

// ==== ex_alu.sv ====
// Execute stage ALU with operand select
`timescale 1ns/100ps

module ex_alu #(
    parameter int XLEN = 32
) (
    input  riscv_pkg::src_a_e   src_a,
    input  riscv_pkg::src_b_e   src_b,
    input  riscv_pkg::alu_op_e  alu_op,
    input  riscv_pkg::fwd_sel_e fwd_a,
    input  riscv_pkg::fwd_sel_e fwd_b,
    input  logic [XLEN-1:0]     rs1_data,
    input  logic [XLEN-1:0]     rs2_data,
    input  logic [XLEN-1:0]     mem_result,
    input  logic [XLEN-1:0]     wb_result,
    input  logic [XLEN-1:0]     pc,
    input  logic [XLEN-1:0]     imm,
    output logic [XLEN-1:0]     alu_result
);

    localparam int SHAMT_W = $clog2(XLEN);

    logic [XLEN-1:0]    rs1_val;
    logic [XLEN-1:0]    rs2_val;
    logic [XLEN-1:0]    op_a;
    logic [XLEN-1:0]    op_b;
    logic [SHAMT_W-1:0] shamt;
    logic               lt_s;
    logic               lt_u;

    // Register operands, newest copy of the value
    always_comb begin
        case (fwd_a)
            riscv_pkg::fwd_mem: rs1_val = mem_result;
            riscv_pkg::fwd_wb:  rs1_val = wb_result;
            default:            rs1_val = rs1_data;
        endcase
        case (fwd_b)
            riscv_pkg::fwd_mem: rs2_val = mem_result;
            riscv_pkg::fwd_wb:  rs2_val = wb_result;
            default:            rs2_val = rs2_data;
        endcase
    end

    // Source muxes
    assign op_a = (src_a == riscv_pkg::src_pc) ? pc : rs1_val;
    assign op_b = (src_b == riscv_pkg::src_imm) ? imm : rs2_val;

    // Low bits only, as RV32 and RV64 shifts do
    assign shamt = op_b[SHAMT_W-1:0];

    assign lt_s = $signed(op_a) < $signed(op_b);
    assign lt_u = op_a < op_b;

    always_comb begin
        case (alu_op)
            riscv_pkg::alu_add:  alu_result = op_a + op_b;
            riscv_pkg::alu_sub:  alu_result = op_a - op_b;
            riscv_pkg::alu_and:  alu_result = op_a & op_b;
            riscv_pkg::alu_or:   alu_result = op_a | op_b;
            riscv_pkg::alu_xor:  alu_result = op_a ^ op_b;
            riscv_pkg::alu_sll:  alu_result = op_a << shamt;
            riscv_pkg::alu_srl:  alu_result = op_a >> shamt;
            riscv_pkg::alu_sra:  alu_result = $unsigned($signed(op_a) >>> shamt);
            // Compare results are a single 0 or 1
            riscv_pkg::alu_slt:  alu_result = {{(XLEN-1){1'b0}}, lt_s};
            riscv_pkg::alu_sltu: alu_result = {{(XLEN-1){1'b0}}, lt_u};
            default:             alu_result = '0;
        endcase
    end

endmodule

// ==== result_pipe.sv ====
// EX/MEM and MEM/WB result registers
`timescale 1ns/100ps

module result_pipe #(
    parameter int XLEN = 32
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 ex_valid,
    input  logic                 ex_reg_write,
    input  riscv_pkg::reg_addr_t ex_rd,
    input  logic [XLEN-1:0]      alu_result,
    output logic                 mem_valid,
    output logic                 mem_reg_write,
    output riscv_pkg::reg_addr_t mem_rd,
    output logic [XLEN-1:0]      mem_result,
    output logic                 wb_valid,
    output logic                 wb_reg_write,
    output riscv_pkg::reg_addr_t wb_rd,
    output logic [XLEN-1:0]      wb_result
);

    // Control fields, a bubble travels as valid low
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_valid     <= 1'b0;
            mem_reg_write <= 1'b0;
            mem_rd        <= '0;
            wb_valid      <= 1'b0;
            wb_reg_write  <= 1'b0;
            wb_rd         <= '0;
        end else begin
            mem_valid     <= ex_valid;
            mem_reg_write <= ex_reg_write;
            mem_rd        <= ex_rd;
            wb_valid      <= mem_valid;
            wb_reg_write  <= mem_reg_write;
            wb_rd         <= mem_rd;
        end
    end

    // Result payload
    always_ff @(posedge clk) begin
        mem_result <= alu_result;
        wb_result  <= mem_result;
    end

    // Both stages flushed by one reset edge
    a_wb_idle_after_rst: assert property (
        @(posedge clk) rst |=> !wb_valid
    ) else $error("result_pipe: wb_valid high in cycle after reset");

endmodule

// ==== ex_pipe_top.sv ====
// Execute pipe top level
`timescale 1ns/100ps

module ex_pipe_top #(
    parameter int XLEN = 32
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 valid,
    input  riscv_pkg::reg_addr_t rs1,
    input  riscv_pkg::reg_addr_t rs2,
    input  riscv_pkg::reg_addr_t rd,
    input  logic                 reg_write,
    input  riscv_pkg::src_a_e    src_a,
    input  riscv_pkg::src_b_e    src_b,
    input  riscv_pkg::alu_op_e   alu_op,
    input  logic [XLEN-1:0]      pc,
    input  logic [XLEN-1:0]      imm,
    output logic                 wb_valid,
    output riscv_pkg::reg_addr_t wb_rd,
    output logic                 wb_reg_write,
    output logic [XLEN-1:0]      wb_result
);

    // Register read data
    logic [XLEN-1:0]      rs1_data;
    logic [XLEN-1:0]      rs2_data;

    // Forward selects
    riscv_pkg::fwd_sel_e  fwd_a;
    riscv_pkg::fwd_sel_e  fwd_b;

    // EX result and MEM stage
    logic [XLEN-1:0]      alu_result;
    logic                 mem_valid;
    logic                 mem_reg_write;
    riscv_pkg::reg_addr_t mem_rd;
    logic [XLEN-1:0]      mem_result;

    // Write-back enable, x0 filtered in the register file
    logic                 rf_we;

    assign rf_we = wb_valid && wb_reg_write;

    fu fu_i (
        .ex_rs1        (rs1),
        .ex_rs2        (rs2),
        .src_a         (src_a),
        .src_b         (src_b),
        .mem_valid     (mem_valid),
        .mem_reg_write (mem_reg_write),
        .mem_rd        (mem_rd),
        .wb_valid      (wb_valid),
        .wb_reg_write  (wb_reg_write),
        .wb_rd         (wb_rd),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b)
    );

    regfile #(.XLEN(XLEN)) regfile_i (
        .clk      (clk),
        .rst      (rst),
        .rs1      (rs1),
        .rs2      (rs2),
        .we       (rf_we),
        .rd       (wb_rd),
        .wdata    (wb_result),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    ex_alu #(.XLEN(XLEN)) ex_alu_i (
        .src_a      (src_a),
        .src_b      (src_b),
        .alu_op     (alu_op),
        .fwd_a      (fwd_a),
        .fwd_b      (fwd_b),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .mem_result (mem_result),
        .wb_result  (wb_result),
        .pc         (pc),
        .imm        (imm),
        .alu_result (alu_result)
    );

    result_pipe #(.XLEN(XLEN)) result_pipe_i (
        .clk           (clk),
        .rst           (rst),
        .ex_valid      (valid),
        .ex_reg_write  (reg_write),
        .ex_rd         (rd),
        .alu_result    (alu_result),
        .mem_valid     (mem_valid),
        .mem_reg_write (mem_reg_write),
        .mem_rd        (mem_rd),
        .mem_result    (mem_result),
        .wb_valid      (wb_valid),
        .wb_reg_write  (wb_reg_write),
        .wb_rd         (wb_rd),
        .wb_result     (wb_result)
    );

endmodule

// ==== tb_ex_pipe_top.sv ====
// Execute pipe testbench
`timescale 1ns/100ps

module tb_ex_pipe_top;

    localparam int XLEN       = 32;
    localparam int RST_CYCLES = 10;
    localparam int NUM_INSTR  = 400;
    // Reset, instruction slots, two drain cycles, then margin
    localparam int MAX_CYCLES = RST_CYCLES + NUM_INSTR + 90;

    // One expected write-back slot
    typedef struct packed {
        logic            valid;
        logic            reg_write;
        logic [4:0]      rd;
        logic [XLEN-1:0] result;
    } wb_exp_t;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 valid;
    riscv_pkg::reg_addr_t rs1;
    riscv_pkg::reg_addr_t rs2;
    riscv_pkg::reg_addr_t rd;
    logic                 reg_write;
    riscv_pkg::src_a_e    src_a;
    riscv_pkg::src_b_e    src_b;
    riscv_pkg::alu_op_e   alu_op;
    logic [XLEN-1:0]      pc;
    logic [XLEN-1:0]      imm;
    logic                 wb_valid;
    riscv_pkg::reg_addr_t wb_rd;
    logic                 wb_reg_write;
    logic [XLEN-1:0]      wb_result;

    // In-order reference state
    logic [XLEN-1:0] model_regs [32];
    wb_exp_t         exp_q [$];
    logic [31:0]     lfsr_state = 32'h3a67_404c;
    int              cycles = 0;
    int              checks = 0;
    int              mismatches = 0;
    int              other_errors = 0;

    ex_pipe_top #(.XLEN(XLEN)) ex_pipe_top_i (
        .clk          (clk),
        .rst          (rst),
        .valid        (valid),
        .rs1          (rs1),
        .rs2          (rs2),
        .rd           (rd),
        .reg_write    (reg_write),
        .src_a        (src_a),
        .src_b        (src_b),
        .alu_op       (alu_op),
        .pc           (pc),
        .imm          (imm),
        .wb_valid     (wb_valid),
        .wb_rd        (wb_rd),
        .wb_reg_write (wb_reg_write),
        .wb_result    (wb_result)
    );

    always #20 clk = ~clk;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit
    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
    endtask

    // RV32I integer semantics
    function automatic logic [XLEN-1:0] model_alu(input riscv_pkg::alu_op_e op,
                                                  input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b);
        logic [4:0]      sh;
        logic [XLEN-1:0] res;
        sh = b[4:0];
        case (op)
            riscv_pkg::alu_add:  res = a + b;
            riscv_pkg::alu_sub:  res = a - b;
            riscv_pkg::alu_and:  res = a & b;
            riscv_pkg::alu_or:   res = a | b;
            riscv_pkg::alu_xor:  res = a ^ b;
            riscv_pkg::alu_sll:  res = a << sh;
            riscv_pkg::alu_srl:  res = a >> sh;
            // Sign fill of the vacated top bits
            riscv_pkg::alu_sra:  res = (a >> sh) | ({XLEN{a[XLEN-1]}} & ~({XLEN{1'b1}} >> sh));
            // Signed compare by flipping the sign bits
            riscv_pkg::alu_slt:  res = ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
            riscv_pkg::alu_sltu: res = (a < b) ? 32'd1 : 32'd0;
            default:             res = '0;
        endcase
        return res;
    endfunction

    task automatic check_value(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Write-back compare on the falling edge
    always @(negedge clk) begin
        wb_exp_t e;
        if (exp_q.size() == 0) begin
            other_errors++;
            $display("error at %0t ns: no expected write-back entry left", $time);
        end else begin
            e = exp_q.pop_front();
            check_value("wb_valid", wb_valid, e.valid);
            if (e.valid) begin
                check_value("wb_rd", wb_rd, e.rd);
                check_value("wb_reg_write", wb_reg_write, e.reg_write);
                check_value("wb_result", wb_result, e.result);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not end within %0d cycles", MAX_CYCLES);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        logic [31:0]          r;
        logic                 i_valid;
        logic                 i_wr;
        riscv_pkg::reg_addr_t i_rs1;
        riscv_pkg::reg_addr_t i_rs2;
        riscv_pkg::reg_addr_t i_rd;
        riscv_pkg::src_a_e    i_src_a;
        riscv_pkg::src_b_e    i_src_b;
        riscv_pkg::alu_op_e   i_op;
        logic [XLEN-1:0]      i_pc;
        logic [XLEN-1:0]      i_imm;
        logic [XLEN-1:0]      op_a;
        logic [XLEN-1:0]      op_b;
        wb_exp_t              e;
        rst       = 1'b1;
        valid     = 1'b0;
        rs1       = '0;
        rs2       = '0;
        rd        = '0;
        reg_write = 1'b0;
        src_a     = riscv_pkg::src_rs1;
        src_b     = riscv_pkg::src_rs2;
        alu_op    = riscv_pkg::alu_add;
        pc        = '0;
        imm       = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        // Two-stage latency before the first slot reaches WB
        exp_q.push_back('0);
        exp_q.push_back('0);
        for (int c = 0; c < RST_CYCLES + NUM_INSTR + 2; c++) begin
            @(posedge clk);
            draw_bits(3, r);
            i_valid = (r[2:0] != 3'd0);
            draw_bits(3, r);
            i_wr = (r[2:0] != 3'd0);
            // x0 to x7 only so hazards are common
            draw_bits(3, r);
            i_rs1 = {2'b00, r[2:0]};
            draw_bits(3, r);
            i_rs2 = {2'b00, r[2:0]};
            draw_bits(3, r);
            i_rd = {2'b00, r[2:0]};
            draw_bits(1, r);
            i_src_a = riscv_pkg::src_a_e'(r[0]);
            draw_bits(1, r);
            i_src_b = riscv_pkg::src_b_e'(r[0]);
            draw_bits(4, r);
            r = r % 32'd10;
            i_op = riscv_pkg::alu_op_e'(r[3:0]);
            draw_bits(32, i_pc);
            draw_bits(32, i_imm);
            // Bubbles during reset and drain
            if (c < RST_CYCLES || c >= RST_CYCLES + NUM_INSTR) begin
                i_valid = 1'b0;
            end
            if (c == RST_CYCLES - 1) begin
                rst <= 1'b0;
            end
            valid     <= i_valid;
            reg_write <= i_wr;
            rs1       <= i_rs1;
            rs2       <= i_rs2;
            rd        <= i_rd;
            src_a     <= i_src_a;
            src_b     <= i_src_b;
            alu_op    <= i_op;
            pc        <= i_pc;
            imm       <= i_imm;
            // Model runs each instruction to completion without forwarding
            op_a = (i_src_a == riscv_pkg::src_pc) ? i_pc : model_regs[i_rs1];
            op_b = (i_src_b == riscv_pkg::src_imm) ? i_imm : model_regs[i_rs2];
            e.valid     = i_valid;
            e.reg_write = i_wr;
            e.rd        = i_rd;
            e.result    = model_alu(i_op, op_a, op_b);
            exp_q.push_back(e);
            if (i_valid && i_wr && (i_rd != 5'd0)) begin
                model_regs[i_rd] = e.result;
            end
        end
        @(posedge clk);
        $display("checks %0d, mismatches %0d, other errors %0d",
                 checks, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== project.f ====
riscv_pkg.sv
fu.sv
regfile.sv
ex_alu.sv
result_pipe.sv
ex_pipe_top.sv
tb_ex_pipe_top.sv

// ==== Bender.yml ====
package:
  name: ex_pipe

sources:
  - files:
      - riscv_pkg.sv
      - fu.sv
      - regfile.sv
      - ex_alu.sv
      - result_pipe.sv
      - ex_pipe_top.sv
  - target: simulation
    files:
      - tb_ex_pipe_top.sv
